// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_CNT   = 16;
    localparam int REG_IDX_W = 4;
    localparam int OPC_W     = 5;
    localparam int CONST_W   = 19;  // Sign-extended C field in IR[18:0]

    // Instruction opcodes found in IR[31:27]
    typedef enum logic [OPC_W-1:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd7,
        op_or   = 5'd8,
        op_shr  = 5'd9,
        op_shl  = 5'd10,
        op_neg  = 5'd16,
        op_not  = 5'd17,
        op_halt = 5'd27
    } opcode_t;

    // Shifts use bus[4:0] as the amount
    typedef enum logic [3:0] {
        alu_pass_b,
        alu_inc_b,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_shl,
        alu_shr,
        alu_neg,
        alu_not
    } alu_op_t;

    // Single driver of the shared bus where bus_none drives zero
    typedef enum logic [2:0] {
        bus_none,
        bus_reg,
        bus_pc,
        bus_mdr,
        bus_zlow,
        bus_const_c
    } bus_src_t;

    typedef enum logic [2:0] {
        step_t0,
        step_t1,
        step_t2,
        step_t3,
        step_t4,
        step_t5,
        step_halted
    } step_t;

endpackage

`default_nettype wire

// File: datapath/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [cpu_pkg::DATA_W-1:0]     bus,
    input  wire logic [cpu_pkg::REG_IDX_W-1:0]  reg_idx,
    input  wire logic                           reg_load,
    output logic      [cpu_pkg::DATA_W-1:0]     reg_data
);

    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [REG_CNT];

    // R0 is an ordinary register like the rest
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_CNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (reg_load)
        begin
            regs[reg_idx] <= bus;
        end
    end

    assign reg_data = regs[reg_idx];  // Read port faces the bus mux

endmodule

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [cpu_pkg::DATA_W-1:0]  bus,
    input  wire logic                        y_load,
    input  wire logic                        z_load,
    input  wire cpu_pkg::alu_op_t            alu_op,
    output logic      [cpu_pkg::DATA_W-1:0]  z_data
);

    import cpu_pkg::*;

    logic [DATA_W-1:0] y_reg;
    logic [DATA_W-1:0] z_reg;
    logic [DATA_W-1:0] result;
    logic [4:0]        shamt;

    assign shamt = bus[4:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            y_reg <= '0;
        end
        else if (y_load)
        begin
            y_reg <= bus;  // First operand of two-operand ops
        end
    end

    // Y is the left operand, the bus the right one
    always_comb
    begin
        case (alu_op)
            alu_pass_b: result = bus;
            alu_inc_b:  result = bus + DATA_W'(1);  // PC increment during fetch
            alu_add:    result = y_reg + bus;
            alu_sub:    result = y_reg - bus;
            alu_and:    result = y_reg & bus;
            alu_or:     result = y_reg | bus;
            alu_shl:    result = y_reg << shamt;
            alu_shr:    result = y_reg >> shamt;  // Logical shift
            alu_neg:    result = -bus;
            alu_not:    result = ~bus;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            z_reg <= '0;
        end
        else if (z_load)
        begin
            z_reg <= result;
        end
    end

    assign z_data = z_reg;

    // The control unit must never latch Z from an undefined operation
    a_alu_op_defined: assert property (@(posedge clk) disable iff (rst)
        z_load |-> (!$isunknown(alu_op) && alu_op inside {alu_pass_b, alu_inc_b,
            alu_add, alu_sub, alu_and, alu_or, alu_shl, alu_shr, alu_neg, alu_not}));

endmodule

`default_nettype wire

// File: datapath/memory_interface.sv
`timescale 1ns/1ps
`default_nettype none

module memory_interface (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [cpu_pkg::DATA_W-1:0]  bus,
    input  wire logic                        mar_load,
    input  wire logic                        mdr_load,
    input  wire logic                        mdr_from_mem,
    input  wire logic [cpu_pkg::DATA_W-1:0]  mem_rdata,
    output logic      [cpu_pkg::DATA_W-1:0]  mdr_data,
    output logic      [cpu_pkg::DATA_W-1:0]  mem_addr,
    output logic      [cpu_pkg::DATA_W-1:0]  mem_wdata
);

    import cpu_pkg::*;

    logic [DATA_W-1:0] mar;
    logic [DATA_W-1:0] mdr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mar <= '0;
            mdr <= '0;
        end
        else
        begin
            if (mar_load)
                mar <= bus;
            // Memory data on a read step, else the bus for a store
            if (mdr_load)
                mdr <= mdr_from_mem ? mem_rdata : bus;
        end
    end

    assign mdr_data  = mdr;
    assign mem_addr  = mar;  // Word address
    assign mem_wdata = mdr;

endmodule

`default_nettype wire

// File: datapath/instruction_bus.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_bus (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire cpu_pkg::bus_src_t           bus_src,
    input  wire logic                        pc_load,
    input  wire logic                        ir_load,
    input  wire logic [cpu_pkg::DATA_W-1:0]  reg_data,
    input  wire logic [cpu_pkg::DATA_W-1:0]  mdr_data,
    input  wire logic [cpu_pkg::DATA_W-1:0]  z_data,
    output logic      [cpu_pkg::DATA_W-1:0]  bus,
    output logic      [cpu_pkg::DATA_W-1:0]  ir
);

    import cpu_pkg::*;

    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] ir_reg;
    logic [DATA_W-1:0] const_c;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc     <= '0;  // First fetch from word zero
            ir_reg <= '0;
        end
        else
        begin
            if (pc_load)
                pc <= bus;
            if (ir_load)
                ir_reg <= bus;
        end
    end

    // C field sign-extended to a full word
    assign const_c = {{(DATA_W-CONST_W){ir_reg[CONST_W-1]}}, ir_reg[CONST_W-1:0]};

    always_comb
    begin
        case (bus_src)
            bus_reg:     bus = reg_data;
            bus_pc:      bus = pc;
            bus_mdr:     bus = mdr_data;
            bus_zlow:    bus = z_data;
            bus_const_c: bus = const_c;
            default:     bus = '0;  // bus_none
        endcase
    end

    assign ir = ir_reg;

endmodule

`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           run,
    input  wire logic [cpu_pkg::DATA_W-1:0]     ir,
    output cpu_pkg::bus_src_t                   bus_src,
    output logic      [cpu_pkg::REG_IDX_W-1:0]  reg_idx,
    output logic                                reg_load,
    output logic                                y_load,
    output logic                                z_load,
    output cpu_pkg::alu_op_t                    alu_op,
    output logic                                pc_load,
    output logic                                ir_load,
    output logic                                mar_load,
    output logic                                mdr_load,
    output logic                                mdr_from_mem,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic                                instr_done,
    output logic                                halted
);

    import cpu_pkg::*;

    step_t                 step;
    step_t                 step_next;
    opcode_t               opcode;
    logic [REG_IDX_W-1:0]  ra;
    logic [REG_IDX_W-1:0]  rb;
    logic [REG_IDX_W-1:0]  rc;

    // Maps an arithmetic or logic opcode onto its ALU operation
    function automatic alu_op_t alu_of(opcode_t opc);
        alu_op_t op;
        case (opc)
            op_add:  op = alu_add;
            op_sub:  op = alu_sub;
            op_and:  op = alu_and;
            op_or:   op = alu_or;
            op_shl:  op = alu_shl;
            op_shr:  op = alu_shr;
            op_neg:  op = alu_neg;
            op_not:  op = alu_not;
            default: op = alu_pass_b;
        endcase
        return op;
    endfunction

    assign opcode = opcode_t'(ir[DATA_W-1 -: OPC_W]);
    assign ra     = ir[26:23];
    assign rb     = ir[22:19];
    assign rc     = ir[18:15];

    always_ff @(posedge clk)
    begin
        if (rst)
            step <= step_t0;
        else
            step <= step_next;
    end

    always_comb
    begin
        bus_src      = bus_none;
        reg_idx      = ra;
        reg_load     = 1'b0;
        y_load       = 1'b0;
        z_load       = 1'b0;
        alu_op       = alu_pass_b;
        pc_load      = 1'b0;
        ir_load      = 1'b0;
        mar_load     = 1'b0;
        mdr_load     = 1'b0;
        mdr_from_mem = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        instr_done   = 1'b0;
        step_next    = step;

        case (step)
            step_t0:
            begin
                // Idle here with no strobes until run allows a fetch
                if (run)
                begin
                    bus_src   = bus_pc;
                    mar_load  = 1'b1;
                    z_load    = 1'b1;
                    alu_op    = alu_inc_b;
                    step_next = step_t1;
                end
            end
            step_t1:
            begin
                bus_src      = bus_zlow;  // PC + 1 back into PC
                pc_load      = 1'b1;
                mem_read     = 1'b1;
                mdr_load     = 1'b1;
                mdr_from_mem = 1'b1;
                step_next    = step_t2;
            end
            step_t2:
            begin
                bus_src   = bus_mdr;
                ir_load   = 1'b1;
                step_next = step_t3;
            end
            step_t3:
            begin
                case (opcode)
                    op_ld, op_st:
                    begin
                        bus_src   = bus_const_c;  // Effective address is C
                        mar_load  = 1'b1;
                        step_next = step_t4;
                    end
                    op_ldi:
                    begin
                        bus_src    = bus_const_c;
                        reg_load   = 1'b1;
                        instr_done = 1'b1;
                        step_next  = step_t0;
                    end
                    op_add, op_sub, op_and, op_or, op_shl, op_shr:
                    begin
                        bus_src   = bus_reg;
                        reg_idx   = rb;
                        y_load    = 1'b1;
                        step_next = step_t4;
                    end
                    op_neg, op_not:
                    begin
                        bus_src   = bus_reg;
                        reg_idx   = rb;
                        z_load    = 1'b1;
                        alu_op    = alu_of(opcode);
                        step_next = step_t4;
                    end
                    op_halt:
                    begin
                        instr_done = 1'b1;
                        step_next  = step_halted;
                    end
                    default:
                    begin
                        instr_done = 1'b1;  // Unknown opcode retires as a no-op
                        step_next  = step_t0;
                    end
                endcase
            end
            step_t4:
            begin
                step_next = step_t5;
                case (opcode)
                    op_ld:
                    begin
                        mem_read     = 1'b1;
                        mdr_load     = 1'b1;
                        mdr_from_mem = 1'b1;
                    end
                    op_st:
                    begin
                        bus_src  = bus_reg;  // ra is the store source
                        mdr_load = 1'b1;
                    end
                    op_add, op_sub, op_and, op_or, op_shl, op_shr:
                    begin
                        bus_src = bus_reg;
                        reg_idx = rc;
                        z_load  = 1'b1;
                        alu_op  = alu_of(opcode);
                    end
                    op_neg, op_not:
                    begin
                        bus_src    = bus_zlow;
                        reg_load   = 1'b1;
                        instr_done = 1'b1;
                        step_next  = step_t0;
                    end
                    default:
                        step_next = step_t0;
                endcase
            end
            step_t5:
            begin
                step_next  = step_t0;
                instr_done = 1'b1;
                case (opcode)
                    op_ld:
                    begin
                        bus_src  = bus_mdr;
                        reg_load = 1'b1;
                    end
                    op_st:
                        mem_write = 1'b1;  // MAR and MDR settled in t3 and t4
                    default:
                    begin
                        bus_src  = bus_zlow;
                        reg_load = 1'b1;
                    end
                endcase
            end
            step_halted:
                step_next = step_halted;  // Left only by reset
            default:
                step_next = step_t0;
        endcase
    end

    assign halted = (step == step_halted);

    a_no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

    // A register cannot be read onto the bus and written back in one step
    a_no_reg_loop: assert property (@(posedge clk) disable iff (rst)
        !(reg_load && bus_src == bus_reg));

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        run,
    input  wire logic [cpu_pkg::DATA_W-1:0]  mem_rdata,
    output logic      [cpu_pkg::DATA_W-1:0]  mem_addr,
    output logic      [cpu_pkg::DATA_W-1:0]  mem_wdata,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             instr_done,
    output logic                             halted
);

    import cpu_pkg::*;

    logic [DATA_W-1:0]     bus;
    logic [DATA_W-1:0]     ir;
    logic [DATA_W-1:0]     reg_data;
    logic [DATA_W-1:0]     mdr_data;
    logic [DATA_W-1:0]     z_data;
    logic [REG_IDX_W-1:0]  reg_idx;
    bus_src_t              bus_src;
    alu_op_t               alu_op;
    logic                  reg_load;
    logic                  y_load;
    logic                  z_load;
    logic                  pc_load;
    logic                  ir_load;
    logic                  mar_load;
    logic                  mdr_load;
    logic                  mdr_from_mem;

    control_unit control_unit_i (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .ir           (ir),
        .bus_src      (bus_src),
        .reg_idx      (reg_idx),
        .reg_load     (reg_load),
        .y_load       (y_load),
        .z_load       (z_load),
        .alu_op       (alu_op),
        .pc_load      (pc_load),
        .ir_load      (ir_load),
        .mar_load     (mar_load),
        .mdr_load     (mdr_load),
        .mdr_from_mem (mdr_from_mem),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .instr_done   (instr_done),
        .halted       (halted)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .reg_idx  (reg_idx),
        .reg_load (reg_load),
        .reg_data (reg_data)
    );

    alu alu_i (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .y_load (y_load),
        .z_load (z_load),
        .alu_op (alu_op),
        .z_data (z_data)
    );

    memory_interface memory_interface_i (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus),
        .mar_load     (mar_load),
        .mdr_load     (mdr_load),
        .mdr_from_mem (mdr_from_mem),
        .mem_rdata    (mem_rdata),
        .mdr_data     (mdr_data),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    // Owns PC, IR and the bus multiplexer
    instruction_bus instruction_bus_i (
        .clk      (clk),
        .rst      (rst),
        .bus_src  (bus_src),
        .pc_load  (pc_load),
        .ir_load  (ir_load),
        .reg_data (reg_data),
        .mdr_data (mdr_data),
        .z_data   (z_data),
        .bus      (bus),
        .ir       (ir)
    );

endmodule

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int MEM_WORDS        = 256;
    localparam int RESET_CYCLES     = 4;
    localparam int MAX_GAP          = 3;   // Longest idle stretch before a fetch
    localparam int POST_HALT_CYCLES = 8;
    localparam int SEED             = 68986;

    // Opcodes as the instruction format defines them
    localparam logic [4:0] OPC_LD   = 5'd0;
    localparam logic [4:0] OPC_ST   = 5'd2;
    localparam logic [4:0] OPC_ADD  = 5'd3;
    localparam logic [4:0] OPC_SUB  = 5'd4;
    localparam logic [4:0] OPC_AND  = 5'd7;
    localparam logic [4:0] OPC_OR   = 5'd8;
    localparam logic [4:0] OPC_SHR  = 5'd9;
    localparam logic [4:0] OPC_SHL  = 5'd10;
    localparam logic [4:0] OPC_NEG  = 5'd16;
    localparam logic [4:0] OPC_NOT  = 5'd17;
    localparam logic [4:0] OPC_HALT = 5'd27;

    logic        clk;
    logic        rst;
    logic        run;
    logic [31:0] mem_rdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;
    logic        instr_done;
    logic        halted;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] w_addr [$];
    logic [31:0] w_data [$];
    logic [31:0] h_addr;
    logic        have_h;
    logic [4:0]  cur_opcode;     // Instruction in flight
    logic [31:0] last_fetch;
    logic        fetch_pending;  // Next read is an instruction fetch
    logic        store_pending;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        halt_due;
    logic        halt_seen;
    int          store_count;
    int          fetch_count;
    int          prog_cycles;
    int          instr_total;
    int          cycle_count;
    int          cycle_limit;
    int          cycles_since;
    int          gap;
    int          idle_left;
    int          post_halt;

    cpu_top cpu_top_i (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .mem_rdata  (mem_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .instr_done (instr_done),
        .halted     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Cycles from t0 up to and including the instr_done step
    function automatic int cycles_for_opcode(input logic [4:0] opc);
        int cycles;
        case (opc)
            OPC_LD, OPC_ST, OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_SHR, OPC_SHL:
                cycles = 6;
            OPC_NEG, OPC_NOT:
                cycles = 5;
            default:
                cycles = 4;  // ldi and halt retire in t3
        endcase
        return cycles;
    endfunction

    task automatic load_trace();
        int               fd;
        int               n;
        logic [7:0]       kind;
        logic [31:0]      addr_v;
        logic [31:0]      data_v;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/program_trace.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the trace file bench/program_trace.txt");
        while ($fscanf(fd, " %c", kind) == 1)
        begin
            case (kind)
                "#":
                    void'($fgets(rest, fd));  // Comment up to end of line
                "M":
                begin
                    n = $fscanf(fd, "%h %h", addr_v, data_v);
                    if (n != 2 || addr_v >= MEM_WORDS)
                        abort_run("Malformed memory record in the trace file");
                    mem[addr_v[7:0]] = data_v;
                end
                "W":
                begin
                    n = $fscanf(fd, "%h %h", addr_v, data_v);
                    if (n != 2)
                        abort_run("Malformed store record in the trace file");
                    w_addr.push_back(addr_v);
                    w_data.push_back(data_v);
                end
                "H":
                begin
                    n = $fscanf(fd, "%h", addr_v);
                    if (n != 1)
                        abort_run("Malformed halt record in the trace file");
                    h_addr = addr_v;
                    have_h = 1'b1;
                end
                default:
                    abort_run("Unknown record kind in the trace file");
            endcase
        end
        $fclose(fd);
    endtask

    initial
    begin
        rst           = 1'b1;
        run           = 1'b0;
        mem_rdata     = '0;
        have_h        = 1'b0;
        h_addr        = '0;
        cur_opcode    = '0;
        last_fetch    = '0;
        fetch_pending = 1'b0;
        store_pending = 1'b0;
        store_addr    = '0;
        store_data    = '0;
        halt_due      = 1'b0;
        halt_seen     = 1'b0;
        store_count   = 0;
        fetch_count   = 0;
        prog_cycles   = 0;
        instr_total   = 0;
        cycle_count   = 0;
        cycles_since  = 0;
        gap           = 0;
        idle_left     = 0;
        post_halt     = 0;
        void'($urandom(SEED));

        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hBAD0_0000 | 32'(i);
        load_trace();
        if (!have_h)
            abort_run("The trace file has no halt record");

        // Straight-line program from word zero up to its halt
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            prog_cycles += cycles_for_opcode(mem[a][31:27]);
            instr_total++;
            if (mem[a][31:27] == OPC_HALT)
                break;
        end
        cycle_limit = 10 * (prog_cycles + instr_total * MAX_GAP) + POST_HALT_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        check_equal(32'(mem_read), 0, "mem_read after reset");
        check_equal(32'(mem_write), 0, "mem_write after reset");
        check_equal(32'(instr_done), 0, "instr_done after reset");
        check_equal(32'(halted), 0, "halted after reset");
        rst           = 1'b0;
        run           = 1'b1;
        cycles_since  = 1;  // This cycle is already the first t0
        fetch_pending = 1'b1;

        while (post_halt < POST_HALT_CYCLES)
        begin
            @(posedge clk);
            if (store_pending)
                mem[store_addr[7:0]] = store_data;
            @(negedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit)
                abort_run("Timeout, the program did not reach halt in time");
            cycles_since++;
            store_pending = 1'b0;
            mem_rdata     = '0;

            if (halt_due)
                check_equal(32'(halted), 1, "halted one cycle after halt retired");
            halt_due = 1'b0;
            if (halted)
            begin
                if (!halt_seen)
                begin
                    check_equal(32'(cur_opcode), 32'(OPC_HALT), "opcode before halted");
                    check_equal(store_count, w_data.size(), "store count at halt");
                    check_equal(last_fetch, h_addr, "last fetch address");
                end
                halt_seen = 1'b1;
                post_halt++;
                if (mem_read || mem_write)
                    abort_run("Memory access after halted was raised");
            end
            else if (halt_seen)
                abort_run("halted dropped without a reset");

            if (mem_read)
            begin
                if (mem_addr >= MEM_WORDS)
                    abort_run("Read address outside the memory model");
                mem_rdata = mem[mem_addr[7:0]];
                if (fetch_pending)
                begin
                    if (fetch_count == 0)
                        check_equal(mem_addr, 0, "first fetch address");
                    cur_opcode    = mem_rdata[31:27];
                    last_fetch    = mem_addr;
                    fetch_pending = 1'b0;
                    fetch_count++;
                end
            end

            if (mem_write)
            begin
                if (store_count >= w_data.size())
                    abort_run("More stores than the trace file expects");
                if (mem_addr >= MEM_WORDS)
                    abort_run("Store address outside the memory model");
                check_equal(mem_addr, w_addr[store_count], "store address");
                check_equal(mem_wdata, w_data[store_count], "store data");
                store_pending = 1'b1;
                store_addr    = mem_addr;
                store_data    = mem_wdata;
                store_count++;
            end

            // Idle gaps hold the DUT in t0 by dropping run for the next cycle
            if (idle_left > 0)
            begin
                run = 1'b0;
                idle_left--;
            end
            else
                run = 1'b1;

            if (instr_done)
            begin
                check_equal(cycles_since, cycles_for_opcode(cur_opcode) + gap,
                            "cycles between instr_done pulses");
                cycles_since  = 0;
                fetch_pending = 1'b1;
                halt_due      = (cur_opcode == OPC_HALT);
                gap           = int'($urandom_range(MAX_GAP, 0));
                idle_left     = gap;
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/program_trace.txt
# Kind, hex address, hex word (M memory image, W expected store in order)
# H line holds the expected address of the last fetch, which is the halt
M 00 08800123  # ldi r1, 0x123
M 01 10800040  # st r1, 0x40
M 02 0907FFFB  # ldi r2, -5
M 03 11000041  # st r2, 0x41
M 04 01800030  # ld r3, 0x30
M 05 02000031  # ld r4, 0x31
M 06 1A9A0000  # add r5, r3, r4
M 07 12800042  # st r5, 0x42
M 08 229A0000  # sub r5, r3, r4
M 09 12800043  # st r5, 0x43
M 0A 3B1A0000  # and r6, r3, r4
M 0B 13000044  # st r6, 0x44
M 0C 439A0000  # or r7, r3, r4
M 0D 13800045  # st r7, 0x45
M 0E 541A0000  # shl r8, r3, r4
M 0F 14000046  # st r8, 0x46
M 10 4C9A0000  # shr r9, r3, r4
M 11 14800047  # st r9, 0x47
M 12 05000032  # ld r10, 0x32
M 13 8DD00000  # not r11, r10
M 14 15800048  # st r11, 0x48
M 15 86500000  # neg r12, r10
M 16 16000049  # st r12, 0x49
M 17 86980000  # neg r13, r3
M 18 1680004A  # st r13, 0x4A
M 19 D8000000  # halt
# Data words, shift amount comes from 0x31 low bits (8)
M 30 12345678
M 31 0000FF08
M 32 F0F0F0F0
W 40 00000123
W 41 FFFFFFFB
W 42 12355580
W 43 12335770
W 44 00005608
W 45 1234FF78
W 46 34567800
W 47 00123456
W 48 0F0F0F0F
W 49 0F0F0F10
W 4A EDCBA988
H 19

// File: vlog.f
common/cpu_pkg.sv
datapath/register_file.sv
datapath/alu.sv
datapath/memory_interface.sv
datapath/instruction_bus.sv
source/control_unit.sv
source/cpu_top.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cpu_tb \
    -f vlog.f \
    -o cpu_sim

./obj_dir/cpu_sim
